// File: source/noc_pkg.sv
package noc_pkg;

  // router ports, four mesh neighbours plus the local port
  localparam int NumPorts = 5;

  // width of a port index, used by the round-robin pointers
  localparam int PortIdxWidth = $clog2(NumPorts);

  // one mesh coordinate, enough for an 8 by 8 mesh
  localparam int CoordWidth = 3;

  // data carried by every flit behind its header
  localparam int PayloadWidth = 32;

  // output direction of a router, also the port index order
  // eject hands the flit to the local port
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_direction_e;

  // router coordinate in the mesh
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } xy_id_t;

  // flit header
  // look_ahead names the output to take at the router that receives the flit
  typedef struct packed {
    xy_id_t           dst_id;
    route_direction_e look_ahead;
  } hdr_t;

  // single-flit packet, header plus payload
  typedef struct packed {
    hdr_t                    hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  // one-hot request from an input port, one bit per output port
  typedef logic [NumPorts-1:0] port_req_t;

endpackage

// File: source/flit_fifo.sv
`timescale 1ns/100ps

module flit_fifo (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           push_valid_i,
  input  noc_pkg::flit_t push_flit_i,
  output logic           push_ready_o,
  output logic           pop_valid_o,
  output noc_pkg::flit_t pop_flit_o,
  input  logic           pop_ready_i
);
  import noc_pkg::*;

  flit_t      mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // full at two entries, empty at zero
  assign push_ready_o = (count_q != 2'd2);
  assign pop_valid_o  = (count_q != 2'd0);
  assign pop_flit_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // simultaneous push and pop leaves the count unchanged
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_flit_i;
    end
  end

endmodule

// File: source/look_ahead_route.sv
`timescale 1ns/100ps

module look_ahead_route (
  input  noc_pkg::xy_id_t           xy_id_i,
  input  noc_pkg::route_direction_e dir_i,
  input  noc_pkg::xy_id_t           dst_id_i,
  output noc_pkg::route_direction_e next_dir_o
);
  import noc_pkg::*;

  xy_id_t xy_id_nxt;

  // coordinate of the router the flit is sent to
  always_comb begin : calc_next_id
    xy_id_nxt = xy_id_i;
    case (dir_i)
      North: begin
        xy_id_nxt.y = xy_id_i.y + CoordWidth'(1);
      end
      South: begin
        xy_id_nxt.y = xy_id_i.y - CoordWidth'(1);
      end
      East: begin
        xy_id_nxt.x = xy_id_i.x + CoordWidth'(1);
      end
      West: begin
        xy_id_nxt.x = xy_id_i.x - CoordWidth'(1);
      end
      default: begin
        xy_id_nxt = xy_id_i;
      end
    endcase
  end

  // xy routing seen from the next router with x resolved first
  always_comb begin : calc_next_dir
    if (dir_i == Eject) begin
      // flit leaves the mesh here so there is nothing to look ahead
      next_dir_o = Eject;
    end else if (xy_id_nxt.x != dst_id_i.x) begin
      if (dst_id_i.x > xy_id_nxt.x) begin
        next_dir_o = East;
      end else begin
        next_dir_o = West;
      end
    end else if (xy_id_nxt.y != dst_id_i.y) begin
      if (dst_id_i.y > xy_id_nxt.y) begin
        next_dir_o = North;
      end else begin
        next_dir_o = South;
      end
    end else begin
      next_dir_o = Eject;
    end
  end

endmodule

// File: source/input_port.sv
`timescale 1ns/100ps

module input_port (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  input  noc_pkg::flit_t     in_flit_i,
  output logic               in_ready_o,
  input  noc_pkg::xy_id_t    xy_id_i,
  output noc_pkg::port_req_t req_o,
  output noc_pkg::flit_t     head_flit_o,
  input  logic               grant_i
);
  import noc_pkg::*;

  logic             head_valid;
  flit_t            head_flit;
  route_direction_e next_dir;

  flit_fifo i_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (in_valid_i),
    .push_flit_i  (in_flit_i),
    .push_ready_o (in_ready_o),
    .pop_valid_o  (head_valid),
    .pop_flit_o   (head_flit),
    .pop_ready_i  (grant_i)
  );

  look_ahead_route i_route (
    .xy_id_i    (xy_id_i),
    .dir_i      (head_flit.hdr.look_ahead),
    .dst_id_i   (head_flit.hdr.dst_id),
    .next_dir_o (next_dir)
  );

  // the head's own look_ahead selects the output here
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      req_o[i] = head_valid && (head_flit.hdr.look_ahead == route_direction_e'(i));
    end
  end

  always_comb begin
    head_flit_o = head_flit;
    head_flit_o.hdr.look_ahead = next_dir;
  end

endmodule

// File: source/output_port.sv
`timescale 1ns/100ps

module output_port (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  noc_pkg::port_req_t                      req_i,
  input  noc_pkg::flit_t [noc_pkg::NumPorts-1:0] head_flits_i,
  output noc_pkg::port_req_t                      grant_o,
  output logic                                    out_valid_o,
  output noc_pkg::flit_t                          out_flit_o,
  input  logic                                    out_ready_i
);
  import noc_pkg::*;

  logic [PortIdxWidth-1:0] rr_ptr_q;
  logic [PortIdxWidth-1:0] winner;
  logic                    found;
  logic                    can_load;
  logic                    load_en;
  logic                    out_valid_q;
  flit_t                   out_flit_q;

  // first requester at or after the pointer with wrap-around
  always_comb begin : rr_search
    int unsigned idx;
    found  = 1'b0;
    winner = rr_ptr_q;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      idx = (32'(rr_ptr_q) + i) % NumPorts;
      if (!found && req_i[idx]) begin
        found  = 1'b1;
        winner = PortIdxWidth'(idx);
      end
    end
  end

  // register is free when empty or drained on this edge
  assign can_load = !out_valid_q || out_ready_i;
  assign load_en  = found && can_load;

  always_comb begin
    grant_o = '0;
    if (load_en) begin
      grant_o[winner] = 1'b1;
    end
  end

  // pointer moves past the winner only on a grant
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (load_en) begin
      if (winner == PortIdxWidth'(NumPorts - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= winner + PortIdxWidth'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (load_en) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // held steady while the downstream stalls
  always_ff @(posedge clk_i) begin
    if (load_en) begin
      out_flit_q <= head_flits_i[winner];
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;

endmodule

// File: source/mesh_router.sv
`timescale 1ns/100ps

module mesh_router (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  noc_pkg::xy_id_t                         xy_id_i,
  input  logic [noc_pkg::NumPorts-1:0]            in_valid_i,
  input  noc_pkg::flit_t [noc_pkg::NumPorts-1:0] in_flit_i,
  output logic [noc_pkg::NumPorts-1:0]            in_ready_o,
  output logic [noc_pkg::NumPorts-1:0]            out_valid_o,
  output noc_pkg::flit_t [noc_pkg::NumPorts-1:0] out_flit_o,
  input  logic [noc_pkg::NumPorts-1:0]            out_ready_i
);
  import noc_pkg::*;

  // in_req is indexed [input][output], out_req and out_grant [output][input]
  port_req_t [NumPorts-1:0] in_req;
  port_req_t [NumPorts-1:0] out_req;
  port_req_t [NumPorts-1:0] out_grant;
  logic [NumPorts-1:0]      in_grant;
  flit_t [NumPorts-1:0]     head_flit;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    input_port i_input_port (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (in_valid_i[i]),
      .in_flit_i   (in_flit_i[i]),
      .in_ready_o  (in_ready_o[i]),
      .xy_id_i     (xy_id_i),
      .req_o       (in_req[i]),
      .head_flit_o (head_flit[i]),
      .grant_i     (in_grant[i])
    );

    // each input is popped by whichever output granted it
    always_comb begin
      in_grant[i] = 1'b0;
      for (int o = 0; o < NumPorts; o++) begin
        in_grant[i] = in_grant[i] | out_grant[o][i];
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    for (genvar i = 0; i < NumPorts; i++) begin : gen_transpose
      assign out_req[o][i] = in_req[i][o];
    end

    output_port i_output_port (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (out_req[o]),
      .head_flits_i (head_flit),
      .grant_o      (out_grant[o]),
      .out_valid_o  (out_valid_o[o]),
      .out_flit_o   (out_flit_o[o]),
      .out_ready_i  (out_ready_i[o])
    );
  end

endmodule

// File: test/tb_mesh_router.sv
`timescale 1ns/100ps

module tb_mesh_router;
  import noc_pkg::*;

  logic                 clk;
  logic                 rst_n;
  xy_id_t               router_id;
  logic [NumPorts-1:0]  in_valid;
  flit_t [NumPorts-1:0] in_flit;
  logic [NumPorts-1:0]  in_ready;
  logic [NumPorts-1:0]  out_valid;
  flit_t [NumPorts-1:0] out_flit;
  logic [NumPorts-1:0]  out_ready;

  integer seed = 82072;
  // flits still to be offered with one queue per input port
  flit_t send_q [NumPorts][$];
  // expected flits indexed by input * NumPorts + output
  flit_t exp_q [NumPorts*NumPorts][$];
  logic [NumPorts-1:0] in_take;
  logic [NumPorts-1:0] held;
  flit_t held_flit [NumPorts];
  string cur_test;
  int test_err;
  int err_cnt = 0;
  int fail_cnt = 0;
  int test_cnt = 0;
  int seq_cnt = 0;
  int sent_cnt;
  int recv_cnt;
  int rr_last;
  bit flood_mode;
  bit saw_full;

  // test lengths feed the cycle limit too
  int routing_flits = 200;
  int lookahead_flits = 100;
  int backpressure_flits = 200;
  int fairness_rounds = 12;
  int cycle_limit;
  int cycle_cnt;

  mesh_router mesh_router_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .xy_id_i     (router_id),
    .in_valid_i  (in_valid),
    .in_flit_i   (in_flit),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_flit_o  (out_flit),
    .out_ready_i (out_ready)
  );

  always #20 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  // xy routing from cur toward dst with x first
  function automatic route_direction_e xy_dir(input xy_id_t cur, input xy_id_t dst);
    if (dst.x > cur.x) return East;
    if (dst.x < cur.x) return West;
    if (dst.y > cur.y) return North;
    if (dst.y < cur.y) return South;
    return Eject;
  endfunction

  // flit as it should leave with look_ahead seen from the next hop
  function automatic flit_t expect_out(input flit_t f);
    xy_id_t nxt;
    flit_t  r;
    nxt = router_id;
    r   = f;
    case (f.hdr.look_ahead)
      North:   nxt.y = nxt.y + CoordWidth'(1);
      South:   nxt.y = nxt.y - CoordWidth'(1);
      East:    nxt.x = nxt.x + CoordWidth'(1);
      West:    nxt.x = nxt.x - CoordWidth'(1);
      default: nxt = router_id;
    endcase
    if (f.hdr.look_ahead == Eject) begin
      r.hdr.look_ahead = Eject;
    end else begin
      r.hdr.look_ahead = xy_dir(nxt, f.hdr.dst_id);
    end
    return r;
  endfunction

  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
      test_err++;
    end
  endtask

  // the upstream router picks look_ahead
  // payload holds source port, sequence number and random bits
  task automatic queue_flit(input xy_id_t dst, input int forced_src);
    flit_t f;
    int    src;
    f.hdr.dst_id     = dst;
    f.hdr.look_ahead = xy_dir(router_id, dst);
    if (forced_src >= 0) begin
      src = forced_src;
    end else begin
      src = rand_below(NumPorts - 1);
      if (src >= int'(f.hdr.look_ahead)) begin
        src++;
      end
    end
    f.payload = {3'(src), 13'(seq_cnt), 16'(rand_below(65536))};
    seq_cnt++;
    send_q[src].push_back(f);
  endtask

  task automatic take_output(input int o);
    flit_t got;
    flit_t exp;
    int    src;
    int    nxt;
    got = out_flit[o];
    src = int'(got.payload[31:29]);
    recv_cnt++;
    if (src >= NumPorts) begin
      $display("error in %s: output %0d sent a flit with a bad source field, %h",
               cur_test, o, got);
      test_err++;
    end else if (exp_q[src * NumPorts + o].size() == 0) begin
      $display("error in %s: output %0d sent a flit that was not expected, %h",
               cur_test, o, got);
      test_err++;
    end else begin
      exp = exp_q[src * NumPorts + o].pop_front();
      check("flit", 64'(exp), 64'(got));
    end
    // cyclic order over inputs 0, 2, 3 and 4
    if (flood_mode && o == int'(East)) begin
      if (rr_last >= 0) begin
        nxt = (rr_last + 1) % NumPorts;
        if (nxt == int'(East)) begin
          nxt = nxt + 1;
        end
        check("round-robin source", 64'(nxt), 64'(src));
      end
      rr_last = src;
    end
  endtask

  task automatic step_cycle(input bit bp);
    @(negedge clk);
    for (int p = 0; p < NumPorts; p++) begin
      if (in_take[p]) begin
        in_valid[p] = 1'b0;
      end
      if (!in_valid[p] && send_q[p].size() != 0 && (flood_mode || rand_below(4) != 0)) begin
        in_flit[p]  = send_q[p].pop_front();
        in_valid[p] = 1'b1;
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      out_ready[o] = bp ? (rand_below(10) < 3) : 1'b1;
    end
    // everything below holds until the next rising edge
    for (int p = 0; p < NumPorts; p++) begin
      in_take[p] = in_valid[p] && in_ready[p];
      if (!in_ready[p]) begin
        saw_full = 1'b1;
      end
      if (in_take[p]) begin
        exp_q[p * NumPorts + int'(in_flit[p].hdr.look_ahead)].push_back(expect_out(in_flit[p]));
        sent_cnt++;
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      if (out_valid[o]) begin
        if (held[o]) begin
          check("stalled flit", 64'(held_flit[o]), 64'(out_flit[o]));
        end
        held[o]      = !out_ready[o];
        held_flit[o] = out_flit[o];
        if (out_ready[o]) begin
          take_output(o);
        end
      end else if (held[o]) begin
        $display("error in %s: output %0d dropped a flit before it was taken", cur_test, o);
        test_err++;
        held[o] = 1'b0;
      end
    end
  endtask

  // state of the handshake outputs right after reset
  task automatic check_reset_state();
    cur_test = "reset";
    test_err = 0;
    check("in_ready", 64'({NumPorts{1'b1}}), 64'(in_ready));
    check("out_valid", 64'(0), 64'(out_valid));
    $display("test reset done: %0d errors", test_err);
    test_cnt++;
    err_cnt = err_cnt + test_err;
    if (test_err != 0) begin
      fail_cnt++;
    end
  endtask

  // mode 0 sends anywhere and mode 1 around this router
  // mode 2 floods east from four inputs
  task automatic run_test(input string name, input int n_flits, input int mode, input bit bp);
    xy_id_t dst;
    int     idle;
    int     src;
    bit     pending;
    cur_test   = name;
    test_err   = 0;
    sent_cnt   = 0;
    recv_cnt   = 0;
    rr_last    = -1;
    saw_full   = 1'b0;
    flood_mode = (mode == 2);
    for (int i = 0; i < n_flits; i++) begin
      if (mode == 2) begin
        dst.x = CoordWidth'(5 + rand_below(3));
        dst.y = CoordWidth'(rand_below(8));
        src   = i % 4;
        if (src >= int'(East)) begin
          src++;
        end
        queue_flit(dst, src);
      end else begin
        if (mode == 1) begin
          dst.x = CoordWidth'(2 + rand_below(3));
          dst.y = CoordWidth'(2 + rand_below(3));
        end else begin
          dst.x = CoordWidth'(rand_below(8));
          dst.y = CoordWidth'(rand_below(8));
        end
        queue_flit(dst, -1);
      end
    end
    idle = 0;
    while (idle < 8) begin
      step_cycle(bp);
      pending = 1'b0;
      for (int p = 0; p < NumPorts; p++) begin
        pending = pending || (send_q[p].size() != 0);
      end
      if (!pending && in_valid == '0 && out_valid == '0) begin
        idle++;
      end else begin
        idle = 0;
      end
    end
    for (int q = 0; q < NumPorts * NumPorts; q++) begin
      if (exp_q[q].size() != 0) begin
        $display("error in %s: %0d flits from input %0d to output %0d never came out",
                 name, exp_q[q].size(), q / NumPorts, q % NumPorts);
        test_err++;
        exp_q[q].delete();
      end
    end
    if (bp && !saw_full) begin
      $display("error in %s: in_ready never went low while outputs stalled", name);
      test_err++;
    end
    $display("test %s done: %0d flits sent, %0d received, %0d errors",
             name, sent_cnt, recv_cnt, test_err);
    test_cnt++;
    err_cnt = err_cnt + test_err;
    if (test_err != 0) begin
      fail_cnt++;
    end
  endtask

  initial begin : main
    clk         = 1'b0;
    rst_n       = 1'b0;
    router_id.x = CoordWidth'(3);
    router_id.y = CoordWidth'(3);
    in_valid    = '0;
    in_flit     = '0;
    out_ready   = '0;
    in_take     = '0;
    held        = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    check_reset_state();
    run_test("routing", routing_flits, 0, 1'b0);
    run_test("lookahead", lookahead_flits, 1, 1'b0);
    run_test("backpressure", backpressure_flits, 0, 1'b1);
    run_test("fairness", 4 * fairness_rounds, 2, 1'b0);
    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // limit of 20 cycles per flit plus margin for reset and draining
  initial begin : watchdog
    cycle_limit = 20 * (routing_flits + lookahead_flits + backpressure_flits
                        + 4 * fairness_rounds) + 200;
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: verilog.f
source/noc_pkg.sv
source/flit_fifo.sv
source/look_ahead_route.sv
source/input_port.sv
source/output_port.sv
source/mesh_router.sv
test/tb_mesh_router.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tb_mesh_router
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
